//--- hw/echo_server.sv
`timescale 1ns/1ps
`include "net_app_settings.svh"

module echo_server (
  input  logic aclk,
  input  logic aresetn,
  input  net_app_pkg::tcp_rx_meta_t tcp_rx_meta,
  input  logic tcp_rx_meta_valid,
  output logic tcp_rx_meta_ready,
  input  net_app_pkg::net_beat_t tcp_rx,
  input  logic tcp_rx_valid,
  output logic tcp_rx_ready,
  output net_app_pkg::tcp_tx_meta_t tcp_tx_meta,
  output logic tcp_tx_meta_valid,
  input  logic tcp_tx_meta_ready,
  output net_app_pkg::net_beat_t tcp_tx,
  output logic tcp_tx_valid,
  input  logic tcp_tx_ready
);

  localparam int DEPTH = `ECHO_DEPTH;
  localparam int AW = $clog2(DEPTH);

  net_app_pkg::echo_state_e state;
  logic [`NET_DATA_W-1:0] data_mem [DEPTH]; // packet store
  logic [`NET_KEEP_W-1:0] keep_mem [DEPTH];
  logic [AW:0] wr_cnt; // stored words
  logic [AW-1:0] rd_ptr;
  logic [15:0] byte_cnt;
  logic [15:0] session_q;
  logic meta_have; // metadata taken for this packet
  logic data_done; // last input beat taken
  logic meta_fire, rx_fire, tx_fire;
  logic buf_full, rd_last;

  function automatic logic [15:0] keep_bytes(input logic [`NET_KEEP_W-1:0] k);
    logic [15:0] n;
    n = '0;
    for (int i = 0; i < `NET_KEEP_W; i++) begin
      n = n + {15'd0, k[i]};
    end
    return n;
  endfunction

  assign tcp_rx_meta_ready = (state == net_app_pkg::ECHO_FILL) && !meta_have;
  assign tcp_rx_ready = (state == net_app_pkg::ECHO_FILL) && !data_done; // low until drained
  assign meta_fire = tcp_rx_meta_valid && tcp_rx_meta_ready;
  assign rx_fire = tcp_rx_valid && tcp_rx_ready;
  assign tx_fire = tcp_tx_valid && tcp_tx_ready;
  assign buf_full = (wr_cnt == DEPTH[AW:0]); // extra words dropped
  assign rd_last = ({1'b0, rd_ptr} == wr_cnt - 1'b1);

  assign tcp_tx_meta_valid = (state == net_app_pkg::ECHO_META);
  assign tcp_tx_meta.session = session_q;
  assign tcp_tx_meta.byte_len = byte_cnt;

  assign tcp_tx_valid = (state == net_app_pkg::ECHO_DRAIN);
  assign tcp_tx.data = data_mem[rd_ptr]; // async read
  assign tcp_tx.keep = keep_mem[rd_ptr];
  assign tcp_tx.last = rd_last; // marks final stored word

  always_ff @(posedge aclk) begin
    if (rx_fire && !buf_full) begin
      data_mem[wr_cnt[AW-1:0]] <= tcp_rx.data;
      keep_mem[wr_cnt[AW-1:0]] <= tcp_rx.keep;
    end
    if (meta_fire) session_q <= tcp_rx_meta.session;
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= net_app_pkg::ECHO_FILL;
      wr_cnt <= '0;
      rd_ptr <= '0;
      byte_cnt <= '0;
      meta_have <= 1'b0;
      data_done <= 1'b0;
    end else begin
      case (state)
        net_app_pkg::ECHO_FILL: begin
          if (rx_fire && !buf_full) begin
            wr_cnt <= wr_cnt + 1'b1;
            byte_cnt <= byte_cnt + keep_bytes(tcp_rx.keep); // bytes from keep
          end
          meta_have <= meta_have | meta_fire;
          data_done <= data_done | (rx_fire & tcp_rx.last);
          if ((meta_have || meta_fire) && (data_done || (rx_fire && tcp_rx.last)))
            state <= net_app_pkg::ECHO_META; // whole packet in hand
        end
        net_app_pkg::ECHO_META: begin
          if (tcp_tx_meta_ready) state <= net_app_pkg::ECHO_DRAIN;
        end
        net_app_pkg::ECHO_DRAIN: begin
          if (tx_fire) begin
            rd_ptr <= rd_ptr + 1'b1;
            if (rd_last) begin // rearm for next packet
              state <= net_app_pkg::ECHO_FILL;
              wr_cnt <= '0;
              rd_ptr <= '0;
              byte_cnt <= '0;
              meta_have <= 1'b0;
              data_done <= 1'b0;
            end
          end
        end
        default: state <= net_app_pkg::ECHO_FILL;
      endcase
    end
  end

endmodule

//--- hw/net_app_pkg.sv
`include "net_app_settings.svh"

package net_app_pkg;

  typedef struct packed {
    logic [`NET_DATA_W-1:0] data;
    logic [`NET_KEEP_W-1:0] keep; // byte enables
    logic last; // end of packet
  } net_beat_t;

  typedef struct packed {
    logic [15:0] session;
  } tcp_rx_meta_t;

  typedef struct packed {
    logic [15:0] session;
    logic [15:0] byte_len;
  } tcp_tx_meta_t;

  typedef struct packed {
    logic [31:0] dst_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] byte_len;
  } udp_tx_meta_t;

  typedef enum logic [7:0] {
    SRC_TCP = 8'd1,
    SRC_UDP = 8'd2
  } app_src_e;

  // prefix word put in front of every outbound packet
  typedef struct packed {
    app_src_e source;
    logic [31:0] tag; // session or target ip
    logic [15:0] byte_len;
    logic [7:0] reserved; // always zero
  } net_hdr_t;

  typedef enum logic [1:0] {ECHO_FILL, ECHO_META, ECHO_DRAIN} echo_state_e;
  typedef enum logic [1:0] {GEN_IDLE, GEN_SEND, GEN_GAP, GEN_DONE} gen_state_e;
  typedef enum logic [1:0] {ARB_IDLE, ARB_HDR, ARB_BODY} arb_state_e;

endpackage

//--- hw/net_app_settings.svh
`ifndef NET_APP_SETTINGS_SVH
`define NET_APP_SETTINGS_SVH

// stream geometry
`define NET_DATA_W 64 // one network word
`define NET_KEEP_W 8 // byte enables per word

// echo server packet store
`define ECHO_DEPTH 16 // words, one packet

// addressing, network byte order
`define LOCAL_IP 32'hC0A8030B // 192.168.3.11
`define TARGET_IP 32'hC0A8030A // 192.168.3.10

// udp ports used by the traffic generator
`define UDP_SRC_PORT 16'd5001
`define UDP_DST_PORT 16'd5001

`endif

//--- hw/net_app_top.sv
`timescale 1ns/1ps

module net_app_top (
  input  logic aclk,
  input  logic aresetn,
  input  net_app_pkg::tcp_rx_meta_t tcp_rx_meta,
  input  logic tcp_rx_meta_valid,
  output logic tcp_rx_meta_ready,
  input  net_app_pkg::net_beat_t tcp_rx,
  input  logic tcp_rx_valid,
  output logic tcp_rx_ready,
  input  logic udp_run_req,
  output logic udp_run_ack,
  input  logic [15:0] udp_word_count,
  input  logic [7:0] udp_packet_gap,
  input  logic [15:0] udp_packet_count,
  output net_app_pkg::net_beat_t net_tx,
  output logic net_tx_valid,
  input  logic net_tx_ready
);

  // echo server to arbiter
  net_app_pkg::tcp_tx_meta_t tcp_tx_meta;
  logic tcp_tx_meta_valid, tcp_tx_meta_ready;
  net_app_pkg::net_beat_t tcp_tx;
  logic tcp_tx_valid, tcp_tx_ready;

  // generator to arbiter
  net_app_pkg::udp_tx_meta_t udp_tx_meta;
  logic udp_tx_meta_valid, udp_tx_meta_ready;
  net_app_pkg::net_beat_t udp_tx;
  logic udp_tx_valid, udp_tx_ready;

  echo_server u_echo_server (
    .aclk(aclk), .aresetn(aresetn),
    .tcp_rx_meta(tcp_rx_meta), .tcp_rx_meta_valid(tcp_rx_meta_valid),
    .tcp_rx_meta_ready(tcp_rx_meta_ready),
    .tcp_rx(tcp_rx), .tcp_rx_valid(tcp_rx_valid), .tcp_rx_ready(tcp_rx_ready),
    .tcp_tx_meta(tcp_tx_meta), .tcp_tx_meta_valid(tcp_tx_meta_valid),
    .tcp_tx_meta_ready(tcp_tx_meta_ready),
    .tcp_tx(tcp_tx), .tcp_tx_valid(tcp_tx_valid), .tcp_tx_ready(tcp_tx_ready)
  );

  udp_traffic_gen u_udp_traffic_gen (
    .aclk(aclk), .aresetn(aresetn),
    .udp_run_req(udp_run_req), .udp_run_ack(udp_run_ack),
    .udp_word_count(udp_word_count), .udp_packet_gap(udp_packet_gap),
    .udp_packet_count(udp_packet_count),
    .udp_tx_meta(udp_tx_meta), .udp_tx_meta_valid(udp_tx_meta_valid),
    .udp_tx_meta_ready(udp_tx_meta_ready),
    .udp_tx(udp_tx), .udp_tx_valid(udp_tx_valid), .udp_tx_ready(udp_tx_ready)
  );

  tx_arbiter u_tx_arbiter (
    .aclk(aclk), .aresetn(aresetn),
    .tcp_tx_meta(tcp_tx_meta), .tcp_tx_meta_valid(tcp_tx_meta_valid),
    .tcp_tx_meta_ready(tcp_tx_meta_ready),
    .tcp_tx(tcp_tx), .tcp_tx_valid(tcp_tx_valid), .tcp_tx_ready(tcp_tx_ready),
    .udp_tx_meta(udp_tx_meta), .udp_tx_meta_valid(udp_tx_meta_valid),
    .udp_tx_meta_ready(udp_tx_meta_ready),
    .udp_tx(udp_tx), .udp_tx_valid(udp_tx_valid), .udp_tx_ready(udp_tx_ready),
    .net_tx(net_tx), .net_tx_valid(net_tx_valid), .net_tx_ready(net_tx_ready)
  );

endmodule

//--- hw/tx_arbiter.sv
`timescale 1ns/1ps

module tx_arbiter (
  input  logic aclk,
  input  logic aresetn,
  input  net_app_pkg::tcp_tx_meta_t tcp_tx_meta,
  input  logic tcp_tx_meta_valid,
  output logic tcp_tx_meta_ready,
  input  net_app_pkg::net_beat_t tcp_tx,
  input  logic tcp_tx_valid,
  output logic tcp_tx_ready,
  input  net_app_pkg::udp_tx_meta_t udp_tx_meta,
  input  logic udp_tx_meta_valid,
  output logic udp_tx_meta_ready,
  input  net_app_pkg::net_beat_t udp_tx,
  input  logic udp_tx_valid,
  output logic udp_tx_ready,
  output net_app_pkg::net_beat_t net_tx,
  output logic net_tx_valid,
  input  logic net_tx_ready
);

  net_app_pkg::arb_state_e state;
  net_app_pkg::app_src_e grant; // source owning the packet in flight
  net_app_pkg::net_hdr_t hdr_q;
  logic prefer_udp; // round-robin pointer
  logic pick_tcp, pick_udp;
  logic body_tcp, body_udp;

  assign pick_tcp = tcp_tx_meta_valid && (!udp_tx_meta_valid || !prefer_udp);
  assign pick_udp = udp_tx_meta_valid && !pick_tcp;

  assign tcp_tx_meta_ready = (state == net_app_pkg::ARB_IDLE) && pick_tcp;
  assign udp_tx_meta_ready = (state == net_app_pkg::ARB_IDLE) && pick_udp;

  assign body_tcp = (state == net_app_pkg::ARB_BODY) && (grant == net_app_pkg::SRC_TCP);
  assign body_udp = (state == net_app_pkg::ARB_BODY) && (grant == net_app_pkg::SRC_UDP);
  assign tcp_tx_ready = body_tcp && net_tx_ready; // straight through
  assign udp_tx_ready = body_udp && net_tx_ready;

  always_comb begin
    net_tx.data = hdr_q; // header word by default
    net_tx.keep = '1;
    net_tx.last = 1'b0;
    net_tx_valid = (state == net_app_pkg::ARB_HDR);
    if (body_tcp) begin
      net_tx = tcp_tx;
      net_tx_valid = tcp_tx_valid;
    end else if (body_udp) begin
      net_tx = udp_tx;
      net_tx_valid = udp_tx_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (state == net_app_pkg::ARB_IDLE) begin
      if (pick_tcp)
        hdr_q <= '{source: net_app_pkg::SRC_TCP, tag: {16'd0, tcp_tx_meta.session},
                   byte_len: tcp_tx_meta.byte_len, reserved: 8'd0};
      else if (pick_udp)
        hdr_q <= '{source: net_app_pkg::SRC_UDP, tag: udp_tx_meta.dst_ip,
                   byte_len: udp_tx_meta.byte_len, reserved: 8'd0};
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= net_app_pkg::ARB_IDLE;
      grant <= net_app_pkg::SRC_TCP;
      prefer_udp <= 1'b0; // tcp wins first tie
    end else begin
      case (state)
        net_app_pkg::ARB_IDLE: begin
          if (pick_tcp || pick_udp) begin
            grant <= pick_tcp ? net_app_pkg::SRC_TCP : net_app_pkg::SRC_UDP;
            prefer_udp <= pick_tcp; // other side next time
            state <= net_app_pkg::ARB_HDR;
          end
        end
        net_app_pkg::ARB_HDR: begin
          if (net_tx_ready) state <= net_app_pkg::ARB_BODY;
        end
        net_app_pkg::ARB_BODY: begin
          if (net_tx_valid && net_tx_ready && net_tx.last) state <= net_app_pkg::ARB_IDLE;
        end
        default: state <= net_app_pkg::ARB_IDLE;
      endcase
    end
  end

endmodule

//--- hw/udp_traffic_gen.sv
`timescale 1ns/1ps
`include "net_app_settings.svh"

module udp_traffic_gen (
  input  logic aclk,
  input  logic aresetn,
  input  logic udp_run_req,
  output logic udp_run_ack,
  input  logic [15:0] udp_word_count,
  input  logic [7:0] udp_packet_gap,
  input  logic [15:0] udp_packet_count,
  output net_app_pkg::udp_tx_meta_t udp_tx_meta,
  output logic udp_tx_meta_valid,
  input  logic udp_tx_meta_ready,
  output net_app_pkg::net_beat_t udp_tx,
  output logic udp_tx_valid,
  input  logic udp_tx_ready
);

  net_app_pkg::gen_state_e state;
  logic [15:0] word_cnt_q; // words per packet, at least one
  logic [7:0] gap_q;
  logic [15:0] pkt_total;
  logic [15:0] pkt_idx;
  logic [15:0] word_idx;
  logic [7:0] gap_cnt;
  logic meta_sent; // metadata of current packet taken
  logic word_last, pkt_last, tx_fire;

  assign word_last = (word_idx == word_cnt_q - 1'b1);
  assign pkt_last = (pkt_idx == pkt_total - 1'b1);
  assign tx_fire = udp_tx_valid && udp_tx_ready;

  assign udp_run_ack = (state == net_app_pkg::GEN_DONE);

  assign udp_tx_meta_valid = (state == net_app_pkg::GEN_SEND) && !meta_sent;
  assign udp_tx_meta.dst_ip = `TARGET_IP;
  assign udp_tx_meta.src_port = `UDP_SRC_PORT;
  assign udp_tx_meta.dst_port = `UDP_DST_PORT;
  assign udp_tx_meta.byte_len = {word_cnt_q[12:0], 3'b000}; // 8 bytes per word

  assign udp_tx_valid = (state == net_app_pkg::GEN_SEND) && meta_sent;
  assign udp_tx.data = {16'd0, pkt_idx, 16'd0, word_idx}; // packet | word index
  assign udp_tx.keep = '1;
  assign udp_tx.last = word_last;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= net_app_pkg::GEN_IDLE;
      pkt_idx <= '0;
      word_idx <= '0;
      gap_cnt <= '0;
      meta_sent <= 1'b0;
    end else begin
      case (state)
        net_app_pkg::GEN_IDLE: begin
          pkt_idx <= '0;
          word_idx <= '0;
          meta_sent <= 1'b0;
          if (udp_run_req) begin
            if (udp_packet_count == 16'd0) state <= net_app_pkg::GEN_DONE; // empty run
            else state <= net_app_pkg::GEN_SEND;
          end
        end
        net_app_pkg::GEN_SEND: begin
          if (udp_tx_meta_valid && udp_tx_meta_ready) meta_sent <= 1'b1;
          if (tx_fire) begin
            word_idx <= word_idx + 1'b1;
            if (word_last) begin // packet done
              word_idx <= '0;
              meta_sent <= 1'b0;
              pkt_idx <= pkt_idx + 1'b1;
              gap_cnt <= gap_q - 1'b1;
              if (pkt_last) state <= net_app_pkg::GEN_DONE;
              else if (gap_q != 8'd0) state <= net_app_pkg::GEN_GAP;
            end
          end
        end
        net_app_pkg::GEN_GAP: begin
          gap_cnt <= gap_cnt - 1'b1;
          if (gap_cnt == 8'd0) state <= net_app_pkg::GEN_SEND; // gap cycles spent
        end
        net_app_pkg::GEN_DONE: begin
          if (!udp_run_req) state <= net_app_pkg::GEN_IDLE; // req dropped, release ack
        end
        default: state <= net_app_pkg::GEN_IDLE;
      endcase
    end
  end

  // run settings, sampled when req is first seen
  always_ff @(posedge aclk) begin
    if (state == net_app_pkg::GEN_IDLE && udp_run_req) begin
      word_cnt_q <= (udp_word_count == 16'd0) ? 16'd1 : udp_word_count;
      gap_q <= udp_packet_gap;
      pkt_total <= udp_packet_count;
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the net_app testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_net_app -f sources.f --Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_net_app" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi

//--- sources.f
+incdir+hw
hw/net_app_pkg.sv
hw/echo_server.sv
hw/udp_traffic_gen.sv
hw/tx_arbiter.sv
hw/net_app_top.sv
tb/tb_net_app.sv

//--- tb/tb_net_app.sv
`timescale 1ns/1ps
`include "net_app_settings.svh"

module tb_net_app;

  // cycle budget of each test
  localparam int T_RESET = 20;
  localparam int T_SINGLE = 100;
  localparam int T_RANDOM = 2000; // 20 echoes under back-pressure
  localparam int T_UDP = 300;
  localparam int T_HANDSHAKE = 600;
  localparam int T_MIXED = 1400;
  localparam int WATCHDOG_CYCLES = 4 * (T_RESET + T_SINGLE + T_RANDOM + T_UDP
                                        + T_HANDSHAKE + T_MIXED); // four times the summed budgets

  logic aclk = 1'b0;
  logic aresetn;
  net_app_pkg::tcp_rx_meta_t tcp_rx_meta;
  logic tcp_rx_meta_valid, tcp_rx_meta_ready;
  net_app_pkg::net_beat_t tcp_rx;
  logic tcp_rx_valid, tcp_rx_ready;
  logic udp_run_req, udp_run_ack;
  logic [15:0] udp_word_count, udp_packet_count;
  logic [7:0] udp_packet_gap;
  net_app_pkg::net_beat_t net_tx;
  logic net_tx_valid, net_tx_ready;

  logic [72:0] tcp_q[$]; // expected {data, keep, last} with header first
  logic [72:0] udp_q[$];
  logic [31:0] lfsr_q = 32'he210; // stimulus
  logic [31:0] bp_lfsr = 32'he210; // back-pressure pattern
  logic bp_on; // random net_tx_ready
  logic in_pkt; // monitor between header and last
  logic [7:0] cur_src;
  logic gap_check, udp_prev_done;
  int exp_gap, idle_cnt, udp_pkts;
  int err_cnt, err_at_start, n_pass, n_fail;
  string cur_test;

  always #4 aclk = ~aclk; // 8 ns period

  net_app_top u_net_app_top (
    .aclk(aclk), .aresetn(aresetn),
    .tcp_rx_meta(tcp_rx_meta), .tcp_rx_meta_valid(tcp_rx_meta_valid),
    .tcp_rx_meta_ready(tcp_rx_meta_ready),
    .tcp_rx(tcp_rx), .tcp_rx_valid(tcp_rx_valid), .tcp_rx_ready(tcp_rx_ready),
    .udp_run_req(udp_run_req), .udp_run_ack(udp_run_ack),
    .udp_word_count(udp_word_count), .udp_packet_gap(udp_packet_gap),
    .udp_packet_count(udp_packet_count),
    .net_tx(net_tx), .net_tx_valid(net_tx_valid), .net_tx_ready(net_tx_ready)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // galois step for x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]}; // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  task automatic value_mismatch(input logic [72:0] exp, input logic [72:0] got);
    $display("[FAIL] %s expected %h actual %h", cur_test, exp, got);
    err_cnt++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR in %s: %s", cur_test, what);
    err_cnt++;
  endtask

  task automatic check_beat(input logic [7:0] src, input logic [72:0] got);
    logic [72:0] exp;
    if (src == 8'd1 && tcp_q.size() > 0) exp = tcp_q.pop_front();
    else if (src == 8'd2 && udp_q.size() > 0) exp = udp_q.pop_front();
    else begin
      report_problem("output beat that no expected packet accounts for");
      return;
    end
    if (got !== exp) value_mismatch(exp, got);
  endtask

  // net_tx monitor sampled on the rising edge
  task automatic watch_output();
    forever begin
      @(posedge aclk);
      if (aresetn && udp_run_ack && udp_q.size() != 0)
        report_problem("udp_run_ack high while UDP beats are still outstanding");
      if (aresetn && net_tx_valid && net_tx_ready) begin
        if (!in_pkt) begin // header beat
          cur_src = net_tx.data[63:56];
          in_pkt = 1'b1;
          if (cur_src == 8'd2) begin
            udp_pkts++;
            if (gap_check && udp_prev_done && idle_cnt < exp_gap)
              report_problem("idle gap between UDP packets shorter than programmed");
          end
        end
        check_beat(cur_src, net_tx);
        if (net_tx.last) begin
          in_pkt = 1'b0;
          if (cur_src == 8'd2) udp_prev_done = 1'b1;
        end
      end
      if (net_tx_valid) idle_cnt = 0;
      else idle_cnt++;
    end
  endtask

  task automatic drive_ready();
    forever begin
      @(negedge aclk);
      if (bp_on) begin
        net_tx_ready = bp_lfsr[0];
        bp_lfsr = lfsr_next(bp_lfsr);
      end else net_tx_ready = 1'b1;
    end
  endtask

  task automatic watchdog();
    repeat (WATCHDOG_CYCLES) @(posedge aclk);
    $display("ERROR watchdog expired, test %s did not finish", cur_test);
    $display("Some tests failed");
    $finish;
  endtask

  task automatic tcp_send(input logic [15:0] sess, input int nw, input logic [7:0] last_keep);
    logic [72:0] beats[$];
    logic [63:0] d;
    logic [7:0] k;
    logic [15:0] blen;
    blen = 16'((nw - 1) * 8 + $countones(last_keep)); // bytes named by keep
    tcp_q.push_back({8'd1, 16'd0, sess, blen, 8'd0, 8'hFF, 1'b0});
    for (int i = 0; i < nw; i++) begin
      d = {rand_bits(32), rand_bits(32)};
      k = (i == nw - 1) ? last_keep : 8'hFF;
      beats.push_back({d, k, i == nw - 1});
      tcp_q.push_back({d, k, i == nw - 1}); // echo is verbatim
    end
    @(negedge aclk);
    tcp_rx_meta.session = sess;
    tcp_rx_meta_valid = 1'b1;
    @(posedge aclk);
    while (!tcp_rx_meta_ready) @(posedge aclk);
    @(negedge aclk);
    tcp_rx_meta_valid = 1'b0;
    foreach (beats[i]) begin
      tcp_rx = beats[i];
      tcp_rx_valid = 1'b1;
      @(posedge aclk);
      while (!tcp_rx_ready) @(posedge aclk);
      @(negedge aclk);
    end
    tcp_rx_valid = 1'b0;
  endtask

  task automatic random_tcp(input int count);
    logic [15:0] sess;
    logic [2:0] sh;
    int nw;
    for (int n = 0; n < count; n++) begin
      sess = 16'(rand_bits(16));
      nw = 1 + int'(rand_bits(4)); // 1 to ECHO_DEPTH
      sh = 3'(rand_bits(3));
      tcp_send(sess, nw, 8'hFF >> sh); // partial keep on last word
    end
  endtask

  task automatic pick_udp(output logic [15:0] wc, output logic [7:0] gap,
                          output logic [15:0] cnt);
    wc = 16'(1 + rand_bits(3));
    gap = 8'(rand_bits(4));
    cnt = 16'(1 + rand_bits(3));
  endtask

  task automatic udp_run(input logic [15:0] wc, input logic [7:0] gap, input logic [15:0] cnt);
    for (int p = 0; p < int'(cnt); p++) begin
      udp_q.push_back({8'd2, `TARGET_IP, 16'(wc * 16'd8), 8'd0, 8'hFF, 1'b0});
      for (int w = 0; w < int'(wc); w++)
        udp_q.push_back({32'(p), 32'(w), 8'hFF, w == int'(wc) - 1}); // packet | word
    end
    udp_pkts = 0;
    udp_prev_done = 1'b0;
    exp_gap = int'(gap);
    @(negedge aclk);
    udp_word_count = wc;
    udp_packet_gap = gap;
    udp_packet_count = cnt;
    udp_run_req = 1'b1;
    @(posedge aclk);
    while (!udp_run_ack) @(posedge aclk);
    if (udp_q.size() != 0) report_problem("udp_run_ack rose before the last UDP beat");
    if (udp_pkts != int'(cnt)) value_mismatch(73'(cnt), 73'(udp_pkts));
    @(negedge aclk);
    udp_run_req = 1'b0;
    @(posedge aclk); // generator sees req low here
    @(posedge aclk);
    if (udp_run_ack) report_problem("udp_run_ack still high a cycle after req dropped");
  endtask

  task automatic wait_drain();
    @(posedge aclk);
    while (tcp_q.size() != 0 || udp_q.size() != 0 || in_pkt) @(posedge aclk);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_at_start = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == err_at_start) begin
      n_pass++;
      $display("test %s: ok", cur_test);
    end else begin
      n_fail++;
      $display("test %s: %0d errors", cur_test, err_cnt - err_at_start);
    end
  endtask

  initial begin
    logic [15:0] wc, cnt;
    logic [7:0] gap;
    aresetn = 1'b0;
    tcp_rx_meta = '0;
    tcp_rx_meta_valid = 1'b0;
    tcp_rx = '0;
    tcp_rx_valid = 1'b0;
    udp_run_req = 1'b0;
    udp_word_count = '0;
    udp_packet_gap = '0;
    udp_packet_count = '0;
    net_tx_ready = 1'b1;
    bp_on = 1'b0;
    in_pkt = 1'b0;
    cur_src = '0;
    gap_check = 1'b0;
    udp_prev_done = 1'b0;
    exp_gap = 0;
    idle_cnt = 0;
    udp_pkts = 0;
    err_cnt = 0;
    err_at_start = 0;
    n_pass = 0;
    n_fail = 0;
    cur_test = "reset_state";
    fork
      watch_output();
      drive_ready();
      watchdog();
    join_none
    repeat (4) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;

    start_test("reset_state");
    @(posedge aclk);
    if (net_tx_valid !== 1'b0) value_mismatch(73'd0, 73'(net_tx_valid));
    if (udp_run_ack !== 1'b0) value_mismatch(73'd0, 73'(udp_run_ack));
    if (tcp_rx_ready !== 1'b1) value_mismatch(73'd1, 73'(tcp_rx_ready));
    if (tcp_rx_meta_ready !== 1'b1) value_mismatch(73'd1, 73'(tcp_rx_meta_ready));
    end_test();

    start_test("single_tcp_echo");
    tcp_send(16'h1234, 3, 8'h0F);
    wait_drain();
    end_test();

    start_test("random_tcp_echoes");
    bp_on = 1'b1;
    random_tcp(20);
    wait_drain();
    bp_on = 1'b0;
    end_test();

    start_test("udp_run_alone");
    gap_check = 1'b1; // nothing else shares the line
    pick_udp(wc, gap, cnt);
    udp_run(wc, gap, cnt);
    wait_drain();
    end_test();

    start_test("udp_handshake");
    pick_udp(wc, gap, cnt);
    udp_run(wc, gap, cnt);
    pick_udp(wc, gap, cnt);
    udp_run(wc, gap, cnt); // second run under the same protocol
    wait_drain();
    gap_check = 1'b0;
    end_test();

    start_test("mixed_traffic");
    bp_on = 1'b1;
    pick_udp(wc, gap, cnt);
    fork
      random_tcp(8);
      udp_run(wc, gap, cnt);
    join
    wait_drain();
    bp_on = 1'b0;
    end_test();

    $display("summary: %0d passed, %0d failed, %0d errors", n_pass, n_fail, err_cnt);
    if (n_fail == 0 && err_cnt == 0) $display("All tests passed");
    else $display("Some tests failed");
    $finish;
  end

endmodule
